// ==== ex_config.svh ====
//--------------------
// width settings for the execute stage
// included by the packages and by every module that sizes a port
//--------------------
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// data and address width, one word
`define EX_XLEN 32

// register file address width
`define EX_REG_AW 5

// enum widths for the decoded fields
`define EX_ZONE_W 2
`define EX_ALUOP_W 4

`endif

// ==== rv_isa_pkg.sv ====
//--------------------
// instruction-level encodings shared by decode and execute
// ALU opcodes, branch compares, result zones and fetch-id tags
//--------------------
`include "ex_config.svh"

package rv_isa_pkg;

    typedef enum logic [`EX_ALUOP_W-1:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    // branch funct3, codes 010 and 011 compare false
    typedef enum logic [2:0] {
        CMP_EQ  = 3'b000,
        CMP_NE  = 3'b001,
        CMP_LT  = 3'b100,
        CMP_GE  = 3'b101,
        CMP_LTU = 3'b110,
        CMP_GEU = 3'b111
    } cmp_op_e;

    typedef enum logic [`EX_ZONE_W-1:0] {
        ZONE_NONE    = 2'd0,
        ZONE_REGFILE = 2'd1,
        ZONE_LOADQ   = 2'd2,
        ZONE_STOREQ  = 2'd3
    } zone_e;

    // jump marks the first instruction fetched after a jump
    typedef enum logic {
        SOFID_RUN  = 1'b0,
        SOFID_JUMP = 1'b1
    } sofid_e;

endpackage

// ==== ex_port_pkg.sv ====
//--------------------
// port groups of the execute stage and its internal pipe register
//--------------------
`include "ex_config.svh"

package ex_port_pkg;

    // one decoded instruction from the decode stage
    typedef struct packed {
        logic                    valid;
        rv_isa_pkg::sofid_e      sofid;
        logic [1:0]              ins_size;
        logic                    jump;
        logic                    cond;
        logic                    link;
        rv_isa_pkg::zone_e       zone;
        logic [`EX_XLEN-1:0]     pc;
        rv_isa_pkg::alu_op_e     alu_op;
        logic [`EX_XLEN-1:0]     operand_left;
        logic [`EX_XLEN-1:0]     operand_right;
        logic [`EX_XLEN-1:0]     regs1_data;
        logic [`EX_XLEN-1:0]     cmp_right;
        logic [`EX_XLEN-1:0]     regs2_data;
        logic [`EX_REG_AW-1:0]   regd_addr;
        logic [2:0]              funct3;
    } ids_req_t;

    // controls held for the commit cycle
    typedef struct packed {
        logic                    valid;
        logic                    jump;
        logic                    cond;
        logic                    link;
        logic                    lq_wr;
        logic                    sq_wr;
        logic                    regd_wr;
        logic [`EX_XLEN-1:0]     pc_inc;
        logic [`EX_XLEN-1:0]     regs2_data;
        logic [`EX_REG_AW-1:0]   regd_addr;
        logic [2:0]              funct3;
    } ex_pipe_t;

    // write-back to the register file in decode
    typedef struct packed {
        logic                    cncl_load;
        logic                    wr;
        logic [`EX_REG_AW-1:0]   addr;
        logic [`EX_XLEN-1:0]     data;
    } wb_t;

    typedef struct packed {
        logic                    lq_wr;
        logic                    sq_wr;
        logic [2:0]              funct3;
        logic [`EX_REG_AW-1:0]   regd_addr;
        logic [`EX_XLEN-1:0]     regs2_data;
        logic [`EX_XLEN-1:0]     addr;
    } lsq_req_t;

    typedef struct packed {
        logic                    jump;
        logic [`EX_XLEN-1:0]     addr;
    } hvec_t;

endpackage

// ==== ex_alu.sv ====
//--------------------
// registered ALU and branch comparator
// both results update on an enabled edge and hold otherwise
//--------------------
`include "ex_config.svh"

module ex_alu (
    input  logic                 clk_i,
    input  logic                 resetb_i,
    input  logic                 en_i,
    input  rv_isa_pkg::alu_op_e  alu_op_i,
    input  logic [`EX_XLEN-1:0]  op_left_i,
    input  logic [`EX_XLEN-1:0]  op_right_i,
    input  logic [`EX_XLEN-1:0]  cmp_left_i,
    input  logic [`EX_XLEN-1:0]  cmp_right_i,
    input  rv_isa_pkg::cmp_op_e  cmp_op_i,
    output logic [`EX_XLEN-1:0]  result_o,
    output logic                 cmp_o
);
    import rv_isa_pkg::*;

    logic [`EX_XLEN-1:0] result_d;
    logic                cmp_d;
    logic [4:0]          shamt;

    // rv32 shift amount
    assign shamt = op_right_i[4:0];

    //--------------------
    // arithmetic and logic
    //--------------------
    always_comb begin
        case (alu_op_i)
            ALU_ADD:  result_d = op_left_i + op_right_i;
            ALU_SUB:  result_d = op_left_i - op_right_i;
            ALU_AND:  result_d = op_left_i & op_right_i;
            ALU_OR:   result_d = op_left_i | op_right_i;
            ALU_XOR:  result_d = op_left_i ^ op_right_i;
            ALU_SLL:  result_d = op_left_i << shamt;
            ALU_SRL:  result_d = op_left_i >> shamt;
            ALU_SRA:  result_d = $unsigned($signed(op_left_i) >>> shamt);
            ALU_SLT:  result_d = {{(`EX_XLEN-1){1'b0}}, $signed(op_left_i) < $signed(op_right_i)};
            ALU_SLTU: result_d = {{(`EX_XLEN-1){1'b0}}, op_left_i < op_right_i};
            default:  result_d = '0;
        endcase
    end

    //--------------------
    // branch compare
    //--------------------
    always_comb begin
        case (cmp_op_i)
            CMP_EQ:  cmp_d = (cmp_left_i == cmp_right_i);
            CMP_NE:  cmp_d = (cmp_left_i != cmp_right_i);
            CMP_LT:  cmp_d = ($signed(cmp_left_i) < $signed(cmp_right_i));
            CMP_GE:  cmp_d = ($signed(cmp_left_i) >= $signed(cmp_right_i));
            CMP_LTU: cmp_d = (cmp_left_i < cmp_right_i);
            CMP_GEU: cmp_d = (cmp_left_i >= cmp_right_i);
            // unused funct3 codes never take the branch
            default: cmp_d = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            cmp_o <= 1'b0;
        end else if (en_i) begin
            cmp_o <= cmp_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            result_o <= result_d;
        end
    end

endmodule

// ==== ex_pipe_reg.sv ====
//--------------------
// decode to execute delay register
// decodes the zone and forms the return address on the way in
//--------------------
`include "ex_config.svh"

module ex_pipe_reg (
    input  logic                   clk_i,
    input  logic                   resetb_i,
    input  logic                   en_i,
    input  ex_port_pkg::ids_req_t  ids_req_i,
    output ex_port_pkg::ex_pipe_t  pipe_o
);
    import rv_isa_pkg::*;
    import ex_port_pkg::*;

    ex_pipe_t pipe_d;
    ex_pipe_t pipe_q;
    logic     valid_q;

    //--------------------
    // next-state controls
    //--------------------
    always_comb begin
        pipe_d            = '0;
        pipe_d.valid      = ids_req_i.valid;
        pipe_d.jump       = ids_req_i.jump;
        pipe_d.cond       = ids_req_i.cond;
        pipe_d.link       = ids_req_i.link;
        // one-hot zone flags
        pipe_d.lq_wr      = (ids_req_i.zone == ZONE_LOADQ);
        pipe_d.sq_wr      = (ids_req_i.zone == ZONE_STOREQ);
        pipe_d.regd_wr    = (ids_req_i.zone == ZONE_REGFILE);
        // ins_size counts halfwords
        pipe_d.pc_inc     = ids_req_i.pc + {{(`EX_XLEN-3){1'b0}}, ids_req_i.ins_size, 1'b0};
        pipe_d.regs2_data = ids_req_i.regs2_data;
        pipe_d.regd_addr  = ids_req_i.regd_addr;
        pipe_d.funct3     = ids_req_i.funct3;
    end

    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            valid_q <= 1'b0;
        end else if (en_i) begin
            valid_q <= pipe_d.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            pipe_q <= pipe_d;
        end
    end

    // valid comes from the reset flop
    always_comb begin
        pipe_o       = pipe_q;
        pipe_o.valid = valid_q;
    end

endmodule

// ==== ex_commit.sv ====
//--------------------
// commit logic of the execute stage
// tracks the fetch-id flush state, raises the stall and drives
// write-back, load/store queue and jump outputs
//--------------------
`include "ex_config.svh"

module ex_commit (
    input  logic                   clk_i,
    input  logic                   resetb_i,
    input  ex_port_pkg::ex_pipe_t  pipe_i,
    input  logic [`EX_XLEN-1:0]    alu_result_i,
    input  logic                   alu_cmp_i,
    input  logic                   in_valid_i,
    input  rv_isa_pkg::sofid_e     in_sofid_i,
    input  logic                   lsq_full_i,
    output logic                   stage_en_o,
    output ex_port_pkg::wb_t       wb_o,
    output ex_port_pkg::lsq_req_t  lsq_req_o,
    output ex_port_pkg::hvec_t     hvec_o
);
    import rv_isa_pkg::*;

    sofid_e sofid_q;
    logic   live;
    logic   commit;
    logic   stall;
    logic   jump;

    //--------------------
    // commit qualification
    //--------------------
    // discarded while waiting for the first instruction of a new stream
    assign live   = pipe_i.valid && (sofid_q == SOFID_RUN);
    assign commit = live && (!pipe_i.cond || alu_cmp_i);

    // hold the stage while the queue cannot take the request
    assign stall      = commit && (pipe_i.lq_wr || pipe_i.sq_wr) && lsq_full_i;
    assign stage_en_o = !stall;

    assign jump = stage_en_o && commit && pipe_i.jump;

    //--------------------
    // flush state
    //--------------------
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            sofid_q <= SOFID_RUN;
        end else if (stage_en_o) begin
            if (jump) begin
                sofid_q <= SOFID_JUMP;
            end else if (in_valid_i && (in_sofid_i == sofid_q)) begin
                sofid_q <= SOFID_RUN;
            end
        end
    end

    //--------------------
    // write-back
    //--------------------
    always_comb begin
        wb_o.cncl_load = stage_en_o && !commit && pipe_i.valid && pipe_i.lq_wr;
        wb_o.wr        = stage_en_o && commit && pipe_i.regd_wr;
        wb_o.addr      = pipe_i.regd_addr;
        // links write the return address
        if (pipe_i.link) begin
            wb_o.data = pipe_i.pc_inc;
        end else begin
            wb_o.data = alu_result_i;
        end
    end

    //--------------------
    // queue and jump requests
    //--------------------
    always_comb begin
        lsq_req_o.lq_wr      = stage_en_o && commit && pipe_i.lq_wr;
        lsq_req_o.sq_wr      = stage_en_o && commit && pipe_i.sq_wr;
        lsq_req_o.funct3     = pipe_i.funct3;
        lsq_req_o.regd_addr  = pipe_i.regd_addr;
        lsq_req_o.regs2_data = pipe_i.regs2_data;
        lsq_req_o.addr       = alu_result_i;
    end

    // target comes from the ALU, pc plus offset or rs1 plus offset
    always_comb begin
        hvec_o.jump = jump;
        hvec_o.addr = alu_result_i;
    end

endmodule

// ==== ex_stage.sv ====
//--------------------
// execute stage top
// connects decode, load/store queue and hart vectoring ports
// to the pipe register, the ALU and the commit logic
//--------------------
`include "ex_config.svh"

module ex_stage (
    input  logic                   clk_i,
    input  logic                   resetb_i,
    input  ex_port_pkg::ids_req_t  ids_req_i,
    output logic                   ids_stall_o,
    output ex_port_pkg::wb_t       wb_o,
    input  logic                   lsq_full_i,
    output ex_port_pkg::lsq_req_t  lsq_req_o,
    output ex_port_pkg::hvec_t     hvec_o
);
    import rv_isa_pkg::*;
    import ex_port_pkg::*;

    logic                stage_en;
    ex_pipe_t            pipe;
    logic [`EX_XLEN-1:0] alu_result;
    logic                alu_cmp;

    assign ids_stall_o = !stage_en;

    ex_pipe_reg u_pipe_reg (
        .clk_i     (clk_i),
        .resetb_i  (resetb_i),
        .en_i      (stage_en),
        .ids_req_i (ids_req_i),
        .pipe_o    (pipe)
    );

    // branch compare selected by funct3
    ex_alu u_alu (
        .clk_i       (clk_i),
        .resetb_i    (resetb_i),
        .en_i        (stage_en),
        .alu_op_i    (ids_req_i.alu_op),
        .op_left_i   (ids_req_i.operand_left),
        .op_right_i  (ids_req_i.operand_right),
        .cmp_left_i  (ids_req_i.regs1_data),
        .cmp_right_i (ids_req_i.cmp_right),
        .cmp_op_i    (cmp_op_e'(ids_req_i.funct3)),
        .result_o    (alu_result),
        .cmp_o       (alu_cmp)
    );

    ex_commit u_commit (
        .clk_i        (clk_i),
        .resetb_i     (resetb_i),
        .pipe_i       (pipe),
        .alu_result_i (alu_result),
        .alu_cmp_i    (alu_cmp),
        .in_valid_i   (ids_req_i.valid),
        .in_sofid_i   (ids_req_i.sofid),
        .lsq_full_i   (lsq_full_i),
        .stage_en_o   (stage_en),
        .wb_o         (wb_o),
        .lsq_req_o    (lsq_req_o),
        .hvec_o       (hvec_o)
    );

endmodule

// ==== tb_clk_gen.sv ====
//--------------------
// testbench clock and reset
// 8 ns clock, reset held low for the first four rising edges
//--------------------
module tb_clk_gen (
    output logic clk_o,
    output logic resetb_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    // released just after the fourth rising edge
    initial begin
        resetb_o = 1'b0;
        repeat (4) @(posedge clk_o);
        #1 resetb_o = 1'b1;
    end

endmodule

// ==== tb_ex_stage.sv ====
//--------------------
// table-driven testbench for the execute stage
// each entry is driven, followed by a bubble, and its commit checked
// against a reference model that tracks the flush state itself
//--------------------
`include "ex_config.svh"

module tb_ex_stage;
    timeunit 1ns;
    timeprecision 100ps;

    import rv_isa_pkg::*;
    import ex_port_pkg::*;

    typedef struct packed {
        logic                  wr;
        logic [`EX_REG_AW-1:0] waddr;
        logic [`EX_XLEN-1:0]   wdata;
        logic                  cncl;
        logic                  lq_wr;
        logic                  sq_wr;
        logic                  jump;
        logic [`EX_XLEN-1:0]   addr;
        logic [2:0]            funct3;
        logic [`EX_XLEN-1:0]   sdata;
    } expect_t;

    typedef struct packed {
        ids_req_t   req;
        logic [3:0] full;
        expect_t    exp;
    } entry_t;

    logic     clk;
    logic     resetb;
    ids_req_t ids_req;
    logic     ids_stall;
    logic     lsq_full;
    wb_t      wb;
    lsq_req_t lsq_req;
    hvec_t    hvec;

    entry_t   stim_q[$];
    sofid_e   flush_model;
    integer   seed = 30;
    int       checks = 0;
    int       errors = 0;
    int       other_errors = 0;
    int       cycles = 0;
    int       cycle_limit = 0;

    tb_clk_gen u_clk_gen (
        .clk_o    (clk),
        .resetb_o (resetb)
    );

    ex_stage dut_i (
        .clk_i       (clk),
        .resetb_i    (resetb),
        .ids_req_i   (ids_req),
        .ids_stall_o (ids_stall),
        .wb_o        (wb),
        .lsq_full_i  (lsq_full),
        .lsq_req_o   (lsq_req),
        .hvec_o      (hvec)
    );

    //--------------------
    // reference model
    //--------------------
    function automatic logic [`EX_XLEN-1:0] alu_model(input alu_op_e op,
                                                      input logic [`EX_XLEN-1:0] a,
                                                      input logic [`EX_XLEN-1:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a + ~b + 1;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << sh;
            ALU_SRL:  return a >> sh;
            // fill the vacated high bits with the sign
            ALU_SRA:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            ALU_SLT:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            ALU_SLTU: return {31'b0, a < b};
            default:  return '0;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3,
                                          input logic [`EX_XLEN-1:0] x,
                                          input logic [`EX_XLEN-1:0] y);
        logic lt_s;
        lt_s = (x[31] != y[31]) ? x[31] : (x < y);
        case (f3)
            3'b000:  return x == y;
            3'b001:  return x != y;
            3'b100:  return lt_s;
            3'b101:  return !lt_s;
            3'b110:  return x < y;
            3'b111:  return !(x < y);
            default: return 1'b0;
        endcase
    endfunction

    // bubbles between entries never change the flush state
    function automatic expect_t predict(input ids_req_t r);
        expect_t             e;
        logic                live;
        logic                commit;
        logic [`EX_XLEN-1:0] res;
        e = '0;
        if (r.valid && (r.sofid == flush_model)) begin
            flush_model = SOFID_RUN;
        end
        live   = r.valid && (flush_model == SOFID_RUN);
        res    = alu_model(r.alu_op, r.operand_left, r.operand_right);
        commit = live && (!r.cond || branch_taken(r.funct3, r.regs1_data, r.cmp_right));
        e.wr     = commit && (r.zone == ZONE_REGFILE);
        e.waddr  = r.regd_addr;
        e.wdata  = r.link ? (r.pc + 32'(r.ins_size) * 2) : res;
        e.cncl   = r.valid && !commit && (r.zone == ZONE_LOADQ);
        e.lq_wr  = commit && (r.zone == ZONE_LOADQ);
        e.sq_wr  = commit && (r.zone == ZONE_STOREQ);
        e.jump   = commit && r.jump;
        e.addr   = res;
        e.funct3 = r.funct3;
        e.sdata  = r.regs2_data;
        if (e.jump) begin
            flush_model = SOFID_JUMP;
        end
        return e;
    endfunction

    //--------------------
    // stimulus table
    //--------------------
    function automatic ids_req_t base_req(input alu_op_e op, input logic [`EX_XLEN-1:0] a,
                                          input logic [`EX_XLEN-1:0] b, input zone_e zone,
                                          input logic [`EX_REG_AW-1:0] rd);
        ids_req_t r;
        r               = '0;
        r.valid         = 1'b1;
        r.sofid         = SOFID_RUN;
        r.ins_size      = 2'd2;
        r.zone          = zone;
        r.pc            = 32'h0000_1000 + stim_q.size() * 4;
        r.alu_op        = op;
        r.operand_left  = a;
        r.operand_right = b;
        r.regs2_data    = $random(seed);
        r.regd_addr     = rd;
        r.funct3        = 3'b010;
        return r;
    endfunction

    task automatic add_entry(input ids_req_t req, input int full);
        entry_t e;
        e.req  = req;
        e.full = full;
        e.exp  = predict(req);
        stim_q.push_back(e);
    endtask

    task automatic build_table();
        ids_req_t            r;
        logic [2:0]          f3_list [7];
        logic [`EX_XLEN-1:0] x_list [4];
        logic [`EX_XLEN-1:0] y_list [4];
        f3_list = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101, 3'b110, 3'b111};
        // equal, smaller, then a mixed-sign pair each way round
        x_list = '{32'h1234_5678, 32'h0000_0005, 32'hffff_fff0, 32'h0000_0010};
        y_list = '{32'h1234_5678, 32'h0000_0009, 32'h0000_0010, 32'hffff_fff0};
        for (int op = 0; op < 10; op++) begin
            r = base_req(alu_op_e'(op), $random(seed), $random(seed), ZONE_REGFILE, 5'(op + 1));
            add_entry(r, 0);
        end
        // conditional branches, tagged so each one runs after a taken one
        foreach (f3_list[f]) begin
            foreach (x_list[p]) begin
                r              = base_req(ALU_ADD, 0, 32'h0000_0040, ZONE_NONE, 5'd0);
                r.operand_left = r.pc;
                r.sofid        = SOFID_JUMP;
                r.cond         = 1'b1;
                r.jump         = 1'b1;
                r.funct3       = f3_list[f];
                r.regs1_data   = x_list[p];
                r.cmp_right    = y_list[p];
                add_entry(r, 0);
            end
        end
        // jal, then a compressed jalr
        r              = base_req(ALU_ADD, 0, 32'h0000_0100, ZONE_REGFILE, 5'd11);
        r.operand_left = r.pc;
        r.sofid        = SOFID_JUMP;
        r.jump         = 1'b1;
        r.link         = 1'b1;
        add_entry(r, 0);
        r          = base_req(ALU_ADD, $random(seed), 32'h0000_0020, ZONE_REGFILE, 5'd12);
        r.sofid    = SOFID_JUMP;
        r.ins_size = 2'd1;
        r.jump     = 1'b1;
        r.link     = 1'b1;
        add_entry(r, 0);
        // flush after a jump, two stale entries then the new stream
        r              = base_req(ALU_ADD, 0, 32'h0000_0200, ZONE_REGFILE, 5'd13);
        r.operand_left = r.pc;
        r.sofid        = SOFID_JUMP;
        r.jump         = 1'b1;
        r.link         = 1'b1;
        add_entry(r, 0);
        add_entry(base_req(ALU_XOR, $random(seed), $random(seed), ZONE_REGFILE, 5'd14), 0);
        add_entry(base_req(ALU_ADD, 32'h0000_8000, 32'h0000_0010, ZONE_LOADQ, 5'd15), 0);
        r       = base_req(ALU_SUB, $random(seed), $random(seed), ZONE_REGFILE, 5'd16);
        r.sofid = SOFID_JUMP;
        add_entry(r, 0);
        add_entry(base_req(ALU_OR, $random(seed), $random(seed), ZONE_REGFILE, 5'd17), 0);
        // queue full for three cycles
        r        = base_req(ALU_ADD, 32'h0000_9000, 32'h0000_0024, ZONE_LOADQ, 5'd18);
        r.funct3 = 3'b100;
        add_entry(r, 3);
        r = base_req(ALU_ADD, 32'h0000_9100, 32'h0000_0008, ZONE_STOREQ, 5'd0);
        add_entry(r, 3);
    endtask

    //--------------------
    // checks
    //--------------------
    task automatic compare_value(input string name, input logic [`EX_XLEN-1:0] got,
                                 input logic [`EX_XLEN-1:0] want);
        checks++;
        if (got !== want) begin
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, want);
            errors++;
        end
    endtask

    task automatic check_idle();
        compare_value("ids_stall_o", ids_stall, 1'b0);
        compare_value("wb_o.wr", wb.wr, 1'b0);
        compare_value("wb_o.cncl_load", wb.cncl_load, 1'b0);
        compare_value("lsq_req_o.lq_wr", lsq_req.lq_wr, 1'b0);
        compare_value("lsq_req_o.sq_wr", lsq_req.sq_wr, 1'b0);
        compare_value("hvec_o.jump", hvec.jump, 1'b0);
    endtask

    task automatic check_commit(input expect_t e);
        compare_value("wb_o.wr", wb.wr, e.wr);
        compare_value("wb_o.cncl_load", wb.cncl_load, e.cncl);
        compare_value("lsq_req_o.lq_wr", lsq_req.lq_wr, e.lq_wr);
        compare_value("lsq_req_o.sq_wr", lsq_req.sq_wr, e.sq_wr);
        compare_value("hvec_o.jump", hvec.jump, e.jump);
        if (e.wr) begin
            compare_value("wb_o.addr", wb.addr, e.waddr);
            compare_value("wb_o.data", wb.data, e.wdata);
        end
        if (e.lq_wr || e.sq_wr) begin
            compare_value("lsq_req_o.addr", lsq_req.addr, e.addr);
            compare_value("lsq_req_o.funct3", lsq_req.funct3, e.funct3);
            compare_value("lsq_req_o.regd_addr", lsq_req.regd_addr, e.waddr);
            compare_value("lsq_req_o.regs2_data", lsq_req.regs2_data, e.sdata);
        end
        if (e.jump) begin
            compare_value("hvec_o.addr", hvec.addr, e.addr);
        end
    endtask

    task automatic report_counts();
        $display("checks %0d, mismatches %0d, other errors %0d", checks, errors, other_errors);
    endtask

    // run limit from the table length
    always @(posedge clk) begin
        cycles++;
        if ((cycle_limit > 0) && (cycles > cycle_limit)) begin
            $display("ERROR: timeout after %0d cycles, the table did not finish", cycles);
            report_counts();
            $display("Test failed");
            $finish;
        end
    end

    //--------------------
    // main sequence
    //--------------------
    initial begin
        entry_t e;
        int     stall_cycles;
        ids_req     = '0;
        lsq_full    = 1'b0;
        flush_model = SOFID_RUN;
        build_table();
        cycle_limit = stim_q.size() * 8 + 50;

        @(posedge resetb);
        @(posedge clk);
        #1;
        @(negedge clk);
        check_idle();
        @(posedge clk);
        #1;

        foreach (stim_q[i]) begin
            e            = stim_q[i];
            stall_cycles = (e.exp.lq_wr || e.exp.sq_wr) ? e.full : 0;
            ids_req      = e.req;
            lsq_full     = (e.full != 0);
            // pipe holds a bubble, so the last strobe lasted one cycle
            @(negedge clk);
            check_idle();
            @(posedge clk);
            #1;
            // bubble keeps the fields of the entry, only valid drops
            ids_req.valid = 1'b0;
            repeat (stall_cycles) begin
                @(negedge clk);
                compare_value("ids_stall_o", ids_stall, 1'b1);
                compare_value("lsq_req_o.lq_wr", lsq_req.lq_wr, 1'b0);
                compare_value("lsq_req_o.sq_wr", lsq_req.sq_wr, 1'b0);
                @(posedge clk);
                #1;
            end
            lsq_full = 1'b0;
            @(negedge clk);
            if (ids_stall !== 1'b0) begin
                $display("ERROR: entry %0d still stalls after the queue stopped being full", i);
                other_errors++;
            end
            check_commit(e.exp);
            @(posedge clk);
            #1;
        end

        report_counts();
        if ((errors == 0) && (other_errors == 0)) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+.
rv_isa_pkg.sv
ex_port_pkg.sv
ex_alu.sv
ex_pipe_reg.sv
ex_commit.sv
ex_stage.sv
tb_clk_gen.sv
tb_ex_stage.sv
